/* Bender.yml */
package:
  name: issue_queue

sources:
  - regPkg.sv
  - issuePkg.sv
  - issueIf.sv
  - payloadRam.sv
  - ageSelect.sv
  - issueBank.sv
  - execPipe.sv
  - issueQueueTop.sv
  - target: test
    files:
      - tbIssue.sv

/* ageSelect.sv */
`timescale 1ns/100ps

module ageSelect #(
    parameter int DEPTH = 8
) (
    input  logic [DEPTH-1:0]         ready_i,
    input  regPkg::RobIdx            rob_i [DEPTH],
    output logic                     valid_o,
    output logic [$clog2(DEPTH)-1:0] idx_o
);
    import regPkg::*;

    localparam int IDX_WIDTH = $clog2(DEPTH);
    localparam int NODES = 2 * DEPTH - 1;

    // binary tree laid out as a heap, node n has children 2n+1 and 2n+2.
    logic                 nodeValid [NODES];
    RobIdx                nodeRob   [NODES];
    logic [IDX_WIDTH-1:0] nodeIdx   [NODES];

    for (genvar i = 0; i < DEPTH; i++) begin : gLeaf
        assign nodeValid[DEPTH-1+i] = ready_i[i];
        assign nodeRob[DEPTH-1+i] = rob_i[i];
        assign nodeIdx[DEPTH-1+i] = IDX_WIDTH'(i);
    end

    for (genvar n = 0; n < DEPTH - 1; n++) begin : gNode
        logic takeLeft;

        // left wins unless the right one is valid and strictly older.
        assign takeLeft = nodeValid[2*n+1] &
            (~nodeValid[2*n+2] | ~isOlder(nodeRob[2*n+2], nodeRob[2*n+1]));

        assign nodeValid[n] = nodeValid[2*n+1] | nodeValid[2*n+2];
        assign nodeRob[n] = takeLeft ? nodeRob[2*n+1] : nodeRob[2*n+2];
        assign nodeIdx[n] = takeLeft ? nodeIdx[2*n+1] : nodeIdx[2*n+2];
    end

    assign valid_o = nodeValid[0];
    assign idx_o = nodeIdx[0];

endmodule

/* execPipe.sv */
`timescale 1ns/100ps

module execPipe #(
    parameter int PAYLOAD_WIDTH = issuePkg::PAYLOAD_WIDTH_DEF
) (
    input  logic                     clk,
    input  logic                     rst,
    issueIf.pipe                     issue_i,
    input  logic                     redirect_i,
    input  regPkg::RobIdx            redirectRob_i,
    output logic                     wakeValid_o,
    output regPkg::PregIdx           wakeRd_o,
    output logic                     doneValid_o,
    output regPkg::PregIdx           doneRd_o,
    output logic                     doneRdWe_o,
    output regPkg::RobIdx            doneRob_o,
    output logic [PAYLOAD_WIDTH-1:0] donePayload_o
);
    import regPkg::*;
    import issuePkg::*;

    PipeState                 s1State;
    PipeState                 s2State;
    PregIdx                   s1Rd;
    PregIdx                   s2Rd;
    logic                     s1RdWe;
    logic                     s2RdWe;
    RobIdx                    s1Rob;
    RobIdx                    s2Rob;
    logic [PAYLOAD_WIDTH-1:0] s1Payload;
    logic [PAYLOAD_WIDTH-1:0] s2Payload;

    logic killIn;
    logic killS1;
    logic killS2;
    logic s2Live;

    // younger than the redirect point.
    assign killIn = redirect_i & isOlder(redirectRob_i, issue_i.rob);
    assign killS1 = redirect_i & isOlder(redirectRob_i, s1Rob);
    assign killS2 = redirect_i & isOlder(redirectRob_i, s2Rob);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1State <= EMPTY;
            s2State <= EMPTY;
        end else begin
            if (!issue_i.valid) begin
                s1State <= EMPTY;
            end else begin
                s1State <= killIn ? KILLED : BUSY;
            end
            s2State <= (s1State == BUSY && killS1) ? KILLED : s1State;
        end
    end

    always_ff @(posedge clk) begin
        s1Rd <= issue_i.rd;
        s1RdWe <= issue_i.rdWe;
        s1Rob <= issue_i.rob;
        s1Payload <= issue_i.payload;
        s2Rd <= s1Rd;
        s2RdWe <= s1RdWe;
        s2Rob <= s1Rob;
        s2Payload <= s1Payload;
    end

    // a redirect in the done cycle still stops a younger op.
    assign s2Live = (s2State == BUSY) & ~killS2;

    assign doneValid_o = s2Live;
    assign doneRd_o = s2Rd;
    assign doneRdWe_o = s2RdWe;
    assign doneRob_o = s2Rob;
    assign donePayload_o = s2Payload;

    assign wakeValid_o = s2Live & s2RdWe;
    assign wakeRd_o = s2Rd;

endmodule

/* issueBank.sv */
`timescale 1ns/100ps

module issueBank #(
    parameter int DEPTH = 8,
    parameter int PAYLOAD_WIDTH = issuePkg::PAYLOAD_WIDTH_DEF
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dispValid_i,
    input  regPkg::PregIdx                dispRs1_i,
    input  logic                          dispRs1Ready_i,
    input  regPkg::PregIdx                dispRs2_i,
    input  logic                          dispRs2Ready_i,
    input  regPkg::PregIdx                dispRd_i,
    input  logic                          dispRdWe_i,
    input  regPkg::RobIdx                 dispRob_i,
    input  logic [PAYLOAD_WIDTH-1:0]      dispPayload_i,
    input  logic [issuePkg::WB_SIZE-1:0]  wakeValid_i,
    input  regPkg::PregIdx                wakeRd_i [issuePkg::WB_SIZE],
    input  logic                          redirect_i,
    input  regPkg::RobIdx                 redirectRob_i,
    issueIf.bank                          issue_o,
    output logic [$clog2(DEPTH+1)-1:0]    creditReturn_o
);
    import regPkg::*;
    import issuePkg::*;

    localparam int IDX_WIDTH = $clog2(DEPTH);
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    logic [DEPTH-1:0] entryValid;
    logic [DEPTH-1:0] rs1Ready;
    logic [DEPTH-1:0] rs2Ready;
    logic [DEPTH-1:0] entryRdWe;
    PregIdx           entryRs1 [DEPTH];
    PregIdx           entryRs2 [DEPTH];
    PregIdx           entryRd  [DEPTH];
    RobIdx            entryRob [DEPTH];

    logic [DEPTH-1:0]     rs1Wake;
    logic [DEPTH-1:0]     rs2Wake;
    logic                 dispRs1Wake;
    logic                 dispRs2Wake;
    logic [DEPTH-1:0]     ready;
    logic [DEPTH-1:0]     younger;
    logic [IDX_WIDTH-1:0] freeIdx;
    logic                 selValid;
    logic [IDX_WIDTH-1:0] selIdx;
    logic                 dispEn;
    logic [CNT_WIDTH-1:0] flushCount;

    // dispatch is dropped in a redirect cycle.
    assign dispEn = dispValid_i & ~redirect_i;

    // tag match of every wakeup port against both sources.
    always_comb begin
        dispRs1Wake = 1'b0;
        dispRs2Wake = 1'b0;
        rs1Wake = '0;
        rs2Wake = '0;
        for (int j = 0; j < WB_SIZE; j++) begin
            if (wakeValid_i[j]) begin
                dispRs1Wake |= (wakeRd_i[j] == dispRs1_i);
                dispRs2Wake |= (wakeRd_i[j] == dispRs2_i);
                for (int i = 0; i < DEPTH; i++) begin
                    rs1Wake[i] |= (wakeRd_i[j] == entryRs1[i]);
                    rs2Wake[i] |= (wakeRd_i[j] == entryRs2[i]);
                end
            end
        end
    end

    for (genvar i = 0; i < DEPTH; i++) begin : gEntry
        assign ready[i] = entryValid[i] & rs1Ready[i] & rs2Ready[i];
        assign younger[i] = entryValid[i] & isOlder(redirectRob_i, entryRob[i]);
    end

    // lowest free slot wins.
    always_comb begin
        freeIdx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!entryValid[i]) begin
                freeIdx = IDX_WIDTH'(i);
            end
        end
    end

    always_comb begin
        flushCount = '0;
        for (int i = 0; i < DEPTH; i++) begin
            flushCount += CNT_WIDTH'(younger[i]);
        end
    end

    ageSelect #(
        .DEPTH(DEPTH)
    ) select (
        .ready_i(ready),
        .rob_i  (entryRob),
        .valid_o(selValid),
        .idx_o  (selIdx)
    );

    // payload read lines up with the issue register below.
    payloadRam #(
        .DEPTH        (DEPTH),
        .PAYLOAD_WIDTH(PAYLOAD_WIDTH)
    ) payload (
        .clk_i  (clk),
        .we_i   (dispEn),
        .wAddr_i(freeIdx),
        .wData_i(dispPayload_i),
        .rAddr_i(selIdx),
        .rData_o(issue_o.payload)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entryValid <= '0;
            rs1Ready <= '0;
            rs2Ready <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (dispEn && freeIdx == IDX_WIDTH'(i)) begin
                    entryValid[i] <= 1'b1;
                    rs1Ready[i] <= dispRs1Ready_i | dispRs1Wake;
                    rs2Ready[i] <= dispRs2Ready_i | dispRs2Wake;
                end else begin
                    if (redirect_i ? younger[i] : (selValid && selIdx == IDX_WIDTH'(i))) begin
                        entryValid[i] <= 1'b0;
                    end
                    rs1Ready[i] <= rs1Ready[i] | rs1Wake[i];
                    rs2Ready[i] <= rs2Ready[i] | rs2Wake[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispEn) begin
            entryRs1[freeIdx] <= dispRs1_i;
            entryRs2[freeIdx] <= dispRs2_i;
            entryRd[freeIdx] <= dispRd_i;
            entryRdWe[freeIdx] <= dispRdWe_i;
            entryRob[freeIdx] <= dispRob_i;
        end
    end

    // issue register and credit count, no issue in a redirect cycle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_o.valid <= 1'b0;
            creditReturn_o <= '0;
        end else if (redirect_i) begin
            issue_o.valid <= 1'b0;
            // a dropped dispatch hands its credit straight back.
            creditReturn_o <= flushCount + CNT_WIDTH'(dispValid_i);
        end else begin
            issue_o.valid <= selValid;
            creditReturn_o <= CNT_WIDTH'(selValid);
        end
    end

    always_ff @(posedge clk) begin
        issue_o.rd <= entryRd[selIdx];
        issue_o.rdWe <= entryRdWe[selIdx];
        issue_o.rob <= entryRob[selIdx];
    end

endmodule

/* issueIf.sv */
`timescale 1ns/100ps

interface issueIf #(
    parameter int PAYLOAD_WIDTH = issuePkg::PAYLOAD_WIDTH_DEF
);
    import regPkg::*;

    logic valid;
    PregIdx rd;
    logic rdWe;
    RobIdx rob;
    logic [PAYLOAD_WIDTH-1:0] payload;

    // no ready signal, the pipe takes one op every cycle.
    modport bank (
        output valid, rd, rdWe, rob, payload
    );

    modport pipe (
        input valid, rd, rdWe, rob, payload
    );

endinterface

/* issuePkg.sv */
package issuePkg;

    // wakeup ports into the bank.
    localparam int WB_SIZE = 2;

    // own execution pipe.
    localparam int WAKE_PIPE = 0;

    // other functional units.
    localparam int WAKE_EXT = 1;

    localparam int PAYLOAD_WIDTH_DEF = 16;

    // slot state of one execution pipe stage.
    // KILLED keeps a flushed op moving down the pipe without completing.
    typedef enum logic [1:0] {
        EMPTY,
        BUSY,
        KILLED
    } PipeState;

endpackage

/* issueQueueTop.sv */
`timescale 1ns/100ps

module issueQueueTop #(
    parameter int DEPTH = 8,
    parameter int PAYLOAD_WIDTH = issuePkg::PAYLOAD_WIDTH_DEF
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       dispValid_i,
    input  regPkg::PregIdx             dispRs1_i,
    input  logic                       dispRs1Ready_i,
    input  regPkg::PregIdx             dispRs2_i,
    input  logic                       dispRs2Ready_i,
    input  regPkg::PregIdx             dispRd_i,
    input  logic                       dispRdWe_i,
    input  regPkg::RobIdx              dispRob_i,
    input  logic [PAYLOAD_WIDTH-1:0]   dispPayload_i,
    input  logic                       extWakeValid_i,
    input  regPkg::PregIdx             extWakeRd_i,
    input  logic                       redirect_i,
    input  regPkg::RobIdx              redirectRob_i,
    output logic [$clog2(DEPTH+1)-1:0] creditReturn_o,
    output logic                       doneValid_o,
    output regPkg::PregIdx             doneRd_o,
    output logic                       doneRdWe_o,
    output regPkg::RobIdx              doneRob_o,
    output logic [PAYLOAD_WIDTH-1:0]   donePayload_o
);
    import regPkg::*;
    import issuePkg::*;

    logic               pipeWakeValid;
    PregIdx             pipeWakeRd;
    logic [WB_SIZE-1:0] wakeValid;
    PregIdx             wakeRd [WB_SIZE];

    issueIf #(
        .PAYLOAD_WIDTH(PAYLOAD_WIDTH)
    ) issueBus ();

    // wakeup bus into the bank.
    assign wakeValid[WAKE_PIPE] = pipeWakeValid;
    assign wakeValid[WAKE_EXT] = extWakeValid_i;
    assign wakeRd[WAKE_PIPE] = pipeWakeRd;
    assign wakeRd[WAKE_EXT] = extWakeRd_i;

    issueBank #(
        .DEPTH        (DEPTH),
        .PAYLOAD_WIDTH(PAYLOAD_WIDTH)
    ) bank (
        .clk           (clk),
        .rst           (rst),
        .dispValid_i   (dispValid_i),
        .dispRs1_i     (dispRs1_i),
        .dispRs1Ready_i(dispRs1Ready_i),
        .dispRs2_i     (dispRs2_i),
        .dispRs2Ready_i(dispRs2Ready_i),
        .dispRd_i      (dispRd_i),
        .dispRdWe_i    (dispRdWe_i),
        .dispRob_i     (dispRob_i),
        .dispPayload_i (dispPayload_i),
        .wakeValid_i   (wakeValid),
        .wakeRd_i      (wakeRd),
        .redirect_i    (redirect_i),
        .redirectRob_i (redirectRob_i),
        .issue_o       (issueBus.bank),
        .creditReturn_o(creditReturn_o)
    );

    execPipe #(
        .PAYLOAD_WIDTH(PAYLOAD_WIDTH)
    ) pipe (
        .clk          (clk),
        .rst          (rst),
        .issue_i      (issueBus.pipe),
        .redirect_i   (redirect_i),
        .redirectRob_i(redirectRob_i),
        .wakeValid_o  (pipeWakeValid),
        .wakeRd_o     (pipeWakeRd),
        .doneValid_o  (doneValid_o),
        .doneRd_o     (doneRd_o),
        .doneRdWe_o   (doneRdWe_o),
        .doneRob_o    (doneRob_o),
        .donePayload_o(donePayload_o)
    );

endmodule

/* payloadRam.sv */
`timescale 1ns/100ps

module payloadRam #(
    parameter int DEPTH = 8,
    parameter int PAYLOAD_WIDTH = issuePkg::PAYLOAD_WIDTH_DEF
) (
    input  logic                     clk_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] wAddr_i,
    input  logic [PAYLOAD_WIDTH-1:0] wData_i,
    input  logic [$clog2(DEPTH)-1:0] rAddr_i,
    output logic [PAYLOAD_WIDTH-1:0] rData_o
);

    logic [PAYLOAD_WIDTH-1:0] mem [DEPTH];

    // write and read slots never collide, a free slot is never selected.
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[wAddr_i] <= wData_i;
        end
        rData_o <= mem[rAddr_i];
    end

endmodule

/* regPkg.sv */
package regPkg;

    localparam int PREG_WIDTH = 6;
    localparam int ROB_WIDTH = 5;

    // physical register number.
    typedef logic [PREG_WIDTH-1:0] PregIdx;

    // position plus one wrap bit on top.
    typedef logic [ROB_WIDTH:0] RobIdx;

    // true when a was allocated before b.
    // the wrap bits differ once the younger op has lapped the buffer,
    // so a mismatch flips the sense of the position compare.
    function automatic logic isOlder(input RobIdx a, input RobIdx b);
        logic dirDiff;
        logic posLess;
        dirDiff = a[ROB_WIDTH] ^ b[ROB_WIDTH];
        posLess = a[ROB_WIDTH-1:0] < b[ROB_WIDTH-1:0];
        return dirDiff ^ posLess;
    endfunction

endpackage

/* tb.f */
regPkg.sv
issuePkg.sv
issueIf.sv
payloadRam.sv
ageSelect.sv
issueBank.sv
execPipe.sv
issueQueueTop.sv
tbIssue.sv

/* tbIssue.sv */
`timescale 1ns/100ps

module tbIssue;
    import regPkg::*;
    import issuePkg::*;

    localparam int DEPTH = 8;
    localparam int MAX_OPS = 2048;

    logic clk;
    logic rst;
    logic dispValid;
    logic dispRs1Ready;
    logic dispRs2Ready;
    logic dispRdWe;
    PregIdx dispRs1;
    PregIdx dispRs2;
    PregIdx dispRd;
    RobIdx dispRob;
    logic [PAYLOAD_WIDTH_DEF-1:0] dispPayload;
    logic extWakeValid;
    PregIdx extWakeRd;
    logic redirect;
    RobIdx redirectRob;
    logic [$clog2(DEPTH+1)-1:0] creditReturn;
    logic doneValid;
    logic doneRdWe;
    PregIdx doneRd;
    RobIdx doneRob;
    logic [PAYLOAD_WIDTH_DEF-1:0] donePayload;

    // scoreboard indexed by dispatch sequence number.
    PregIdx opRs1 [MAX_OPS];
    PregIdx opRs2 [MAX_OPS];
    PregIdx opRd [MAX_OPS];
    logic opRdWe [MAX_OPS];
    logic [PAYLOAD_WIDTH_DEF-1:0] opPayload [MAX_OPS];
    logic rs1Rdy [MAX_OPS];
    logic rs2Rdy [MAX_OPS];
    int readyCyc [MAX_OPS];
    int doneCyc [MAX_OPS];
    int pending [$];
    int doneOrder [$];

    int errors;
    int completed;
    int flushed;
    int credits;
    int cycle;
    int nextSeq;
    int redirSeq;
    logic [31:0] lfsrState;

    issueQueueTop #(
        .DEPTH        (DEPTH),
        .PAYLOAD_WIDTH(PAYLOAD_WIDTH_DEF)
    ) dut (
        .clk           (clk),
        .rst           (rst),
        .dispValid_i   (dispValid),
        .dispRs1_i     (dispRs1),
        .dispRs1Ready_i(dispRs1Ready),
        .dispRs2_i     (dispRs2),
        .dispRs2Ready_i(dispRs2Ready),
        .dispRd_i      (dispRd),
        .dispRdWe_i    (dispRdWe),
        .dispRob_i     (dispRob),
        .dispPayload_i (dispPayload),
        .extWakeValid_i(extWakeValid),
        .extWakeRd_i   (extWakeRd),
        .redirect_i    (redirect),
        .redirectRob_i (redirectRob),
        .creditReturn_o(creditReturn),
        .doneValid_o   (doneValid),
        .doneRd_o      (doneRd),
        .doneRdWe_o    (doneRdWe),
        .doneRob_o     (doneRob),
        .donePayload_o (donePayload)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic flagError(input string msg);
        errors++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    task automatic dispatchOp(input PregIdx rs1, input logic r1, input PregIdx rs2,
                              input logic r2, input PregIdx rd, input logic we, output int seq);
        seq = nextSeq;
        nextSeq++;
        dispValid = 1'b1;
        dispRs1 = rs1;
        dispRs1Ready = r1;
        dispRs2 = rs2;
        dispRs2Ready = r2;
        dispRd = rd;
        dispRdWe = we;
        dispRob = RobIdx'(seq);
        dispPayload = takeBits(PAYLOAD_WIDTH_DEF);
        opRs1[seq] = rs1;
        opRs2[seq] = rs2;
        opRd[seq] = rd;
        opRdWe[seq] = we;
        opPayload[seq] = dispPayload;
        rs1Rdy[seq] = r1;
        rs2Rdy[seq] = r2;
        readyCyc[seq] = cycle;
        doneCyc[seq] = -1;
        credits--;
        pending.push_back(seq);
    endtask

    task automatic wakeTag(input PregIdx tag);
        extWakeValid = 1'b1;
        extWakeRd = tag;
    endtask

    task automatic redirectTo(input int seq);
        redirect = 1'b1;
        redirectRob = RobIdx'(seq);
        redirSeq = seq;
    endtask

    // reference model of the ready bits.
    task automatic applyWake(input PregIdx tag);
        foreach (pending[k]) begin
            if (opRs1[pending[k]] == tag && !rs1Rdy[pending[k]]) begin
                rs1Rdy[pending[k]] = 1'b1;
                readyCyc[pending[k]] = cycle;
            end
            if (opRs2[pending[k]] == tag && !rs2Rdy[pending[k]]) begin
                rs2Rdy[pending[k]] = 1'b1;
                readyCyc[pending[k]] = cycle;
            end
        end
    endtask

    task automatic observe();
        int hit;
        int s;
        #1;
        if (redirect) begin
            for (int k = pending.size() - 1; k >= 0; k--) begin
                if (pending[k] > redirSeq) begin
                    pending.delete(k);
                    flushed++;
                end
            end
        end
        if (doneValid) begin
            hit = -1;
            foreach (pending[k]) begin
                if (RobIdx'(pending[k]) == doneRob) begin
                    hit = k;
                end
            end
            assert (hit >= 0)
                else flagError($sformatf("rob %0d completed but is not outstanding", doneRob));
            if (hit >= 0) begin
                s = pending[hit];
                pending.delete(hit);
                assert (rs1Rdy[s] && rs2Rdy[s])
                    else flagError($sformatf("op %0d completed before its sources woke", s));
                assert (doneRd == opRd[s] && doneRdWe == opRdWe[s] && donePayload == opPayload[s])
                    else flagError($sformatf("op %0d completed with wrong rd or payload", s));
                assert (cycle >= readyCyc[s] + 4)
                    else flagError($sformatf("op %0d completed too early", s));
                doneCyc[s] = cycle;
                doneOrder.push_back(s);
                completed++;
                if (opRdWe[s]) begin
                    applyWake(opRd[s]);
                end
            end else begin
                // an op that was flushed or never sent.
                for (int q = nextSeq - 1; q >= 0 && q >= nextSeq - 32; q--) begin
                    if (RobIdx'(q) == doneRob && doneCyc[q] < 0) begin
                        doneCyc[q] = cycle;
                    end
                end
            end
        end
        if (extWakeValid) begin
            applyWake(extWakeRd);
        end
        credits += creditReturn;
        assert (credits >= 0 && credits <= DEPTH)
            else flagError($sformatf("credit count out of range at %0d", credits));
        cycle++;
    endtask

    task automatic nextCycle();
        observe();
        @(negedge clk);
        dispValid = 1'b0;
        extWakeValid = 1'b0;
        redirect = 1'b0;
    endtask

    task automatic waitForCredit();
        int n;
        n = 0;
        while (credits == 0 && n < 50) begin
            nextCycle();
            n++;
        end
        if (credits == 0) begin
            $display("timed out waiting for a free credit");
            errors++;
        end
    endtask

    // sweep walks the external wakeup over every register number.
    task automatic waitPending(input int limit, input logic sweep);
        int n;
        n = 0;
        while (pending.size() != 0 && n < limit) begin
            if (sweep) begin
                wakeTag(PregIdx'(n));
            end
            nextCycle();
            n++;
        end
        if (pending.size() != 0) begin
            $display("timed out with %0d ops still outstanding", pending.size());
            errors++;
        end
        repeat (3) nextCycle();
        assert (credits == DEPTH) else flagError("credits did not return to the bank depth");
    endtask

    initial begin
        int s;
        int chain [3];
        int waiters [$];
        logic inOrder;
        lfsrState = 32'h708a;
        errors = 0;
        completed = 0;
        flushed = 0;
        credits = DEPTH;
        cycle = 0;
        nextSeq = 0;
        redirSeq = 0;
        rst = 1'b1;
        dispValid = 1'b0;
        dispRs1 = '0;
        dispRs1Ready = 1'b0;
        dispRs2 = '0;
        dispRs2Ready = 1'b0;
        dispRd = '0;
        dispRdWe = 1'b0;
        dispRob = '0;
        dispPayload = '0;
        extWakeValid = 1'b0;
        extWakeRd = '0;
        redirect = 1'b0;
        redirectRob = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (creditReturn == 0 && !doneValid) else flagError("outputs not idle after reset");

        // producer, consumer and a second consumer woken by the pipe.
        dispatchOp(6'd10, 1'b1, 6'd11, 1'b1, 6'd50, 1'b1, chain[0]);
        nextCycle();
        dispatchOp(6'd50, 1'b0, 6'd11, 1'b1, 6'd51, 1'b1, chain[1]);
        nextCycle();
        dispatchOp(6'd51, 1'b0, 6'd50, 1'b0, 6'd52, 1'b1, chain[2]);
        nextCycle();
        waitPending(40, 1'b0);
        assert (doneCyc[chain[0]] >= 0 && doneCyc[chain[1]] >= doneCyc[chain[0]] + 4 &&
                doneCyc[chain[2]] >= doneCyc[chain[1]] + 4)
            else flagError("dependent op completed too soon after its producer");

        // fillers shuffle the slots so slot order differs from age.
        for (int k = 0; k < 6; k++) begin
            waitForCredit();
            dispatchOp(6'd40, 1'b0, 6'd41, 1'b1, PregIdx'(k), 1'b0, s);
            waiters.push_back(s);
            nextCycle();
            if (k % 2 == 0) begin
                waitForCredit();
                dispatchOp(6'd42, 1'b1, 6'd41, 1'b1, 6'd43, 1'b0, s);
                nextCycle();
            end
        end
        repeat (5) nextCycle();
        doneOrder.delete();
        wakeTag(6'd40);
        nextCycle();
        waitPending(40, 1'b0);
        inOrder = (doneOrder.size() == waiters.size());
        foreach (waiters[k]) begin
            if (k < doneOrder.size() && doneOrder[k] != waiters[k]) begin
                inOrder = 1'b0;
            end
        end
        assert (inOrder) else flagError("ready ops did not complete oldest first");

        // flush the younger three while they still wait.
        waiters.delete();
        for (int k = 0; k < 5; k++) begin
            dispatchOp(6'd45, 1'b0, 6'd41, 1'b1, PregIdx'(k), 1'b0, s);
            waiters.push_back(s);
            nextCycle();
        end
        redirectTo(waiters[1]);
        nextCycle();
        wakeTag(6'd45);
        nextCycle();
        waitPending(40, 1'b0);
        assert (doneCyc[waiters[2]] < 0 && doneCyc[waiters[3]] < 0 && doneCyc[waiters[4]] < 0)
            else flagError("flushed op completed after redirect");

        // random traffic keeps the age window inside half the rob range.
        for (int k = 0; k < 400; k++) begin
            if (pending.size() != 0 && takeBits(5) == 0) begin
                redirectTo(pending[takeBits(3) % pending.size()]);
            end else if (credits > 0 && takeBits(1) &&
                         (pending.size() == 0 || nextSeq - pending[0] < 28)) begin
                dispatchOp(PregIdx'(takeBits(3)), takeBits(1), PregIdx'(takeBits(3)),
                           takeBits(1), PregIdx'(takeBits(3)), takeBits(1), s);
            end
            if (takeBits(2) == 0) begin
                wakeTag(PregIdx'(takeBits(3)));
            end
            nextCycle();
        end
        waitPending(200, 1'b1);

        $display("completed %0d, flushed %0d, errors %0d", completed, flushed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
